/* q2a03.f */
+incdir+testbench
verilog/q2a03_pkg.sv
verilog/cpu_core.sv
verilog/oam_dma.sv
verilog/bus_arbiter.sv
verilog/q2a03.sv
testbench/tb_q2a03.sv

/* testbench/cpu_model.svh */
logic [7:0]  model_mem [0:65535];
logic [15:0] exp_addr_q [$];
logic [7:0]  exp_data_q [$];
logic [15:0] exp_sync_q [$];
int          model_cycles;

task automatic record_write(input logic [15:0] addr, input logic [7:0] data);
  logic [7:0] copied;
  int         i;
  exp_addr_q.push_back(addr);
  exp_data_q.push_back(data);
  model_mem[addr] = data;
  if (addr == dma_trigger_addr)
  begin
    // the DMA copies the page in order, one read and one write per byte.
    for (i = 0; i < dma_length; i++)
    begin
      copied = model_mem[{data, 8'(i)}];
      model_mem[dma_target_addr] = copied;
      exp_addr_q.push_back(dma_target_addr);
      exp_data_q.push_back(copied);
    end
    model_cycles += 2 * dma_length;
  end
endtask

task automatic run_model(input logic [15:0] stop_pc);
  logic [15:0] pc;
  logic [15:0] ea;
  logic [7:0]  a;
  logic [7:0]  x;
  logic [7:0]  p;
  logic [7:0]  op;
  logic [7:0]  opnd;
  logic [8:0]  sum;
  int          len;
  pc           = reset_pc;
  a            = 8'd0;
  x            = 8'd0;
  p            = 8'd0;
  model_cycles = 1;   // the idle bus cycle right after reset.
  while (pc != stop_pc)
  begin
    exp_sync_q.push_back(pc);
    op   = model_mem[pc];
    opnd = model_mem[16'(pc + 1)];
    ea   = {model_mem[16'(pc + 2)], opnd};
    sum  = a + opnd + p[flag_c];
    case (op)
      op_lda_imm, op_ldx_imm, op_adc_imm, op_and_imm, op_eor_imm: len = 2;
      op_lda_abs, op_sta_abs, op_stx_abs, op_jmp_abs: len = 3;
      default: len = 1;
    endcase
    case (op)
      op_lda_imm: a = opnd;
      op_ldx_imm: x = opnd;
      op_adc_imm: {p[flag_c], a} = sum;
      op_and_imm: a = a & opnd;
      op_eor_imm: a = a ^ opnd;
      op_lda_abs: a = model_mem[ea];
      op_sta_abs: record_write(ea, a);
      op_stx_abs: record_write(ea, x);
      op_inx:     x = x + 8'd1;
      op_clc:     p[flag_c] = 1'b0;
      op_sec:     p[flag_c] = 1'b1;
      default:    ;
    endcase
    pc = (op == op_jmp_abs) ? ea : 16'(pc + len);
    model_cycles += (op == op_jmp_abs) ? 3 : ((len == 3) ? 4 : 2);
  end
  exp_sync_q.push_back(stop_pc);
endtask

/* testbench/tb_q2a03.sv */
`default_nettype none

module tb_q2a03
  import q2a03_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clock_period = 10;

  logic        G_clock;
  logic        G_reset;
  logic [7:0]  G_rd_data;
  logic [15:0] G_addr;
  logic [7:0]  G_wr_data;
  logic        G_rdwr;
  logic        G_sync;
  logic        G_phy2;

  logic [7:0]  mem [0:65535];
  integer      seed;
  logic [15:0] gen_pc;
  logic [15:0] final_pc;
  logic        model_ready = 1'b0;
  logic        last_phy2 = 1'b0;
  logic        last_sync = 1'b0;
  logic        last_rdwr = 1'b1;
  logic [15:0] last_addr = 16'd0;
  logic [7:0]  last_data = 8'd0;
  int          clocks_since_fall = 0;
  int          falls_seen = 0;
  int          dma_cycles_left = 0;

  `include "cpu_model.svh"

  q2a03 DUT
  (
    .G_clock   (G_clock),
    .G_reset   (G_reset),
    .G_rd_data (G_rd_data),
    .G_addr    (G_addr),
    .G_wr_data (G_wr_data),
    .G_rdwr    (G_rdwr),
    .G_sync    (G_sync),
    .G_phy2    (G_phy2)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
      stop_with_failure($sformatf("mismatch at %0d ns: %s is %0h, expected %0h",
                                  $time, what, actual, expected));
  endtask

  task automatic fill_memory();
    int i;
    for (i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
  endtask

  task automatic emit(input logic [7:0] op, input int len, input logic [15:0] operand);
    mem[gen_pc] = op;
    if (len > 1)
      mem[16'(gen_pc + 1)] = operand[7:0];
    if (len > 2)
      mem[16'(gen_pc + 2)] = operand[15:8];
    gen_pc = 16'(gen_pc + len);
  endtask

  task automatic make_program();
    int          count;
    int          pick;
    int          dmas;
    logic [7:0]  value;
    logic [15:0] target;
    count  = 0;
    dmas   = 0;
    gen_pc = reset_pc;
    while (count < 59)
    begin
      pick   = $unsigned($random(seed)) % 14;
      value  = 8'($random(seed));
      target = 16'($unsigned($random(seed)) % 2048);   // somewhere in the 2 KB of RAM.
      case (pick)
        0:       emit(op_lda_imm, 2, value);
        1:       emit(op_ldx_imm, 2, value);
        2:       emit(op_adc_imm, 2, value);
        3:       emit(op_and_imm, 2, value);
        4:       emit(op_eor_imm, 2, value);
        5:       emit(op_lda_abs, 3, target);
        6, 7:    emit(op_sta_abs, 3, target);
        8:       emit(op_stx_abs, 3, target);
        9:       emit(op_inx, 1, 16'd0);
        10:      emit(op_clc, 1, 16'd0);
        11:      emit(op_sec, 1, 16'd0);
        12:      emit(op_jmp_abs, 3, 16'(gen_pc + 3));
        default:
        begin
          if (dmas < 3 && count < 58)
          begin
            emit(op_lda_imm, 2, 16'(value % 8));
            emit(op_sta_abs, 3, dma_trigger_addr);
            dmas  = dmas + 1;
            count = count + 1;
          end
          else
            emit(8'hEA, 1, 16'd0);   // outside the subset, so it runs as a nop.
        end
      endcase
      count = count + 1;
    end
    final_pc = gen_pc;
    emit(op_jmp_abs, 3, final_pc);
  endtask

  initial
  begin
    G_clock = 1'b0;
    forever #(clock_period / 2) G_clock = ~G_clock;
  end

  initial
  begin
    seed      = 32'he291;
    G_reset   = 1'b0;
    G_rd_data = 8'd0;
    fill_memory();
    make_program();
    model_mem = mem;
    run_model(final_pc);
    model_ready = 1'b1;
    repeat (16) @(posedge G_clock);
    G_reset <= 1'b1;
  end

  always @(posedge G_clock)
    G_rd_data <= mem[G_addr];

  initial
  begin
    wait (model_ready);
    #((2 * model_cycles + 100) * cycle_divide * clock_period);
    stop_with_failure("watchdog expired before the program reached its final jump");
  end

  // a bus cycle ends where phy2 falls, and its values are the ones sampled one clock earlier.
  always @(posedge G_clock)
  begin
    last_phy2 <= G_phy2;
    last_sync <= G_sync;
    last_rdwr <= G_rdwr;
    last_addr <= G_addr;
    last_data <= G_wr_data;
    clocks_since_fall = clocks_since_fall + 1;
    if (G_reset && last_phy2 && !G_phy2)
    begin
      if (falls_seen > 0)
        check_value(clocks_since_fall, cycle_divide, "clocks per phy2 period");
      falls_seen        = falls_seen + 1;
      clocks_since_fall = 0;
      if (dma_cycles_left > 0)
      begin
        check_value(last_sync, 1'b0, "sync while the DMA owns the bus");
        dma_cycles_left = dma_cycles_left - 1;
      end
      if (!last_rdwr)
      begin
        if (exp_addr_q.size() == 0)
          stop_with_failure($sformatf("write to %h after all expected writes were seen",
                                      last_addr));
        else
        begin
          check_value(last_addr, exp_addr_q.pop_front(), "write address");
          check_value(last_data, exp_data_q.pop_front(), "write data");
          mem[last_addr] = last_data;
          if (last_addr == dma_trigger_addr)
            dma_cycles_left = 2 * dma_length;
        end
      end
      if (last_sync)
      begin
        check_value(last_addr, exp_sync_q.pop_front(), "opcode fetch address");
        if (last_addr == final_pc)
        begin
          if (exp_addr_q.size() != 0)
            stop_with_failure($sformatf("final jump reached with %0d writes still missing",
                                        exp_addr_q.size()));
          else
          begin
            $display("Finished with no errors");
            $finish;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
`default_nettype none

module bus_arbiter import q2a03_pkg::*;
(
  input  wire         G_clock,
  input  wire         G_reset,
  input  wire         halt,
  input  wire  [15:0] core_addr,
  input  wire  [7:0]  core_wr_data,
  input  wire         core_rdwr,
  input  wire         core_sync,
  input  wire  [15:0] dma_addr,
  input  wire  [7:0]  dma_wr_data,
  input  wire         dma_rdwr,
  output logic        core_step,
  output logic        dma_step,
  output logic        G_phy2,
  output logic [15:0] G_addr,
  output logic [7:0]  G_wr_data,
  output logic        G_rdwr,
  output logic        G_sync
);

  logic [3:0] count;
  logic       step;

  // the last tick of a bus cycle, so state moves as phy2 falls.
  assign step = (count == 4'(cycle_divide - 1));

  always_ff @(posedge G_clock or negedge G_reset)
  begin
    if (!G_reset)
      count <= 4'd0;
    else if (step)
      count <= 4'd0;
    else
      count <= count + 4'd1;
  end

  assign G_phy2 = (count >= 4'(phase_high_start));

  assign core_step = step && !halt;   // a halted core keeps its state.
  assign dma_step  = step;

  assign G_addr    = halt ? dma_addr : core_addr;
  assign G_wr_data = halt ? dma_wr_data : core_wr_data;
  assign G_rdwr    = halt ? dma_rdwr : core_rdwr;

  // The frozen core may sit on its fetch cycle, which is not a real fetch.
  assign G_sync = core_sync && !halt;

endmodule

`default_nettype wire

/* verilog/cpu_core.sv */
`default_nettype none

module cpu_core import q2a03_pkg::*;
(
  input  wire         G_clock,
  input  wire         G_reset,
  input  wire         step,
  input  wire  [7:0]  rd_data,
  output logic [15:0] addr,
  output logic [7:0]  wr_data,
  output logic        rdwr,
  output logic        sync
);

  logic [2:0]  curr_cycle;
  logic [2:0]  next_cycle;
  logic [7:0]  curr_a;
  logic [7:0]  next_a;
  logic [7:0]  curr_x;
  logic [7:0]  next_x;
  logic [7:0]  curr_p;
  logic [7:0]  next_p;
  logic [15:0] curr_pc;
  logic [15:0] next_pc;
  opcode_t     curr_ir;
  opcode_t     next_ir;
  logic [7:0]  curr_adl;
  logic [7:0]  next_adl;
  logic [7:0]  curr_adh;
  logic [7:0]  next_adh;

  logic        is_lda;
  logic        is_ldx;
  logic        is_adc;
  logic        is_and;
  logic        is_eor;
  logic        is_sta;
  logic        is_stx;
  logic        is_inx;
  logic        is_clc;
  logic        is_sec;
  logic        is_jmp;
  logic        uses_operand;
  logic        abs_mode;
  logic        imm_mode;
  logic [8:0]  sum;
  logic        nz_update;
  logic [7:0]  nz_value;

  assign is_lda = (curr_ir.whole == op_lda_imm) || (curr_ir.whole == op_lda_abs);
  assign is_ldx = (curr_ir.whole == op_ldx_imm);
  assign is_adc = (curr_ir.whole == op_adc_imm);
  assign is_and = (curr_ir.whole == op_and_imm);
  assign is_eor = (curr_ir.whole == op_eor_imm);
  assign is_sta = (curr_ir.whole == op_sta_abs);
  assign is_stx = (curr_ir.whole == op_stx_abs);
  assign is_inx = (curr_ir.whole == op_inx);
  assign is_clc = (curr_ir.whole == op_clc);
  assign is_sec = (curr_ir.whole == op_sec);
  assign is_jmp = (curr_ir.whole == op_jmp_abs);

  assign uses_operand = is_lda || is_ldx || is_adc || is_and || is_eor;

  // bbb of 011 is absolute in every group, the other modes depend on cc.
  assign abs_mode = (curr_ir.field.bbb == 3'b011) && (is_lda || is_sta || is_stx || is_jmp);
  assign imm_mode = ((curr_ir.field.cc == 2'b01) && (curr_ir.field.bbb == 3'b010)) ||
                    ((curr_ir.field.cc == 2'b10) && (curr_ir.field.bbb == 3'b000));

  assign sum = {1'b0, curr_a} + {1'b0, rd_data} + {8'd0, curr_p[flag_c]};

  assign sync    = (curr_cycle == 3'd0);
  assign addr    = (curr_cycle == 3'd3) ? {curr_adh, curr_adl} : curr_pc;
  assign rdwr    = ~((curr_cycle == 3'd3) && (is_sta || is_stx));
  assign wr_data = is_stx ? curr_x : curr_a;

  always_comb
  begin
    next_cycle = curr_cycle;
    next_a     = curr_a;
    next_x     = curr_x;
    next_p     = curr_p;
    next_pc    = curr_pc;
    next_ir    = curr_ir;
    next_adl   = curr_adl;
    next_adh   = curr_adh;
    nz_update  = 1'b0;
    nz_value   = rd_data;
    case (curr_cycle)
      3'd0:
      begin
        next_ir.whole = rd_data;       // opcode fetch.
        next_pc       = curr_pc + 16'd1;
        next_cycle    = 3'd1;
      end
      3'd1:
      begin
        if (abs_mode)
        begin
          next_adl   = rd_data;
          next_pc    = curr_pc + 16'd1;
          next_cycle = 3'd2;
        end
        else
        begin
          next_cycle = 3'd0;
          // unknown opcodes fall through here as a two cycle nop.
          if (imm_mode && uses_operand)
          begin
            next_pc   = curr_pc + 16'd1;
            nz_update = 1'b1;
          end
          if (imm_mode && is_lda)
            next_a = rd_data;
          if (is_ldx)
            next_x = rd_data;
          if (is_adc)
          begin
            next_a         = sum[7:0];
            next_p[flag_c] = sum[8];
            nz_value       = sum[7:0];
          end
          if (is_and)
          begin
            next_a   = curr_a & rd_data;
            nz_value = curr_a & rd_data;
          end
          if (is_eor)
          begin
            next_a   = curr_a ^ rd_data;
            nz_value = curr_a ^ rd_data;
          end
          if (is_inx)
          begin
            next_x    = curr_x + 8'd1;
            nz_value  = curr_x + 8'd1;
            nz_update = 1'b1;
          end
          if (is_clc)
            next_p[flag_c] = 1'b0;
          if (is_sec)
            next_p[flag_c] = 1'b1;
        end
      end
      3'd2:
      begin
        if (is_jmp)
        begin
          next_pc    = {rd_data, curr_adl};
          next_cycle = 3'd0;
        end
        else
        begin
          next_adh   = rd_data;
          next_pc    = curr_pc + 16'd1;
          next_cycle = 3'd3;
        end
      end
      3'd3:
      begin
        if (is_lda)
        begin
          next_a    = rd_data;
          nz_update = 1'b1;
        end
        next_cycle = 3'd0;
      end
      default:
        next_cycle = 3'd0;            // leave the idle state after reset.
    endcase
    if (nz_update)
    begin
      next_p[flag_z] = (nz_value == 8'd0);
      next_p[flag_n] = nz_value[7];
    end
  end

  always_ff @(posedge G_clock or negedge G_reset)
  begin
    if (!G_reset)
    begin
      curr_cycle    <= 3'b111;
      curr_a        <= 8'd0;
      curr_x        <= 8'd0;
      curr_p        <= 8'd0;
      curr_pc       <= reset_pc;
      curr_ir.whole <= 8'd0;
    end
    else if (step)
    begin
      curr_cycle <= next_cycle;
      curr_a     <= next_a;
      curr_x     <= next_x;
      curr_p     <= next_p;
      curr_pc    <= next_pc;
      curr_ir    <= next_ir;
    end
  end

  always_ff @(posedge G_clock)
  begin
    if (step)
    begin
      curr_adl <= next_adl;
      curr_adh <= next_adh;
    end
  end

endmodule

`default_nettype wire

/* verilog/oam_dma.sv */
`default_nettype none

module oam_dma import q2a03_pkg::*;
(
  input  wire         G_clock,
  input  wire         G_reset,
  input  wire         step,
  input  wire  [15:0] bus_addr,
  input  wire  [7:0]  bus_wr_data,
  input  wire         bus_rdwr,
  input  wire  [7:0]  rd_data,
  output logic        halt,
  output logic [15:0] dma_addr,
  output logic [7:0]  dma_wr_data,
  output logic        dma_rdwr
);

  logic [7:0] page;
  logic [7:0] index;
  logic       write_phase;
  logic       trigger;
  logic       last_write;

  assign trigger    = !halt && !bus_rdwr && (bus_addr == dma_trigger_addr);
  assign last_write = write_phase && (index == 8'(dma_length - 1));

  // reads come from the page, writes all go to the sprite data port.
  assign dma_addr = write_phase ? dma_target_addr : {page, index};
  assign dma_rdwr = ~write_phase;

  always_ff @(posedge G_clock or negedge G_reset)
  begin
    if (!G_reset)
    begin
      halt        <= 1'b0;
      index       <= 8'd0;
      write_phase <= 1'b0;
    end
    else if (step)
    begin
      if (trigger)
      begin
        halt        <= 1'b1;   // the core stops from the next bus cycle.
        index       <= 8'd0;
        write_phase <= 1'b0;
      end
      else if (halt)
      begin
        write_phase <= ~write_phase;
        if (write_phase)
          index <= index + 8'd1;
        if (last_write)
          halt <= 1'b0;
      end
    end
  end

  always_ff @(posedge G_clock)
  begin
    if (step)
    begin
      if (trigger)
        page <= bus_wr_data;
      if (halt && !write_phase)
        dma_wr_data <= rd_data;   // held for the write that follows.
    end
  end

endmodule

`default_nettype wire

/* verilog/q2a03.sv */
`default_nettype none

module q2a03
(
  input  wire        G_clock,
  input  wire        G_reset,
  input  wire [7:0]  G_rd_data,
  output wire [15:0] G_addr,
  output wire [7:0]  G_wr_data,
  output wire        G_rdwr,
  output wire        G_sync,
  output wire        G_phy2
);

  wire        core_step;
  wire        dma_step;
  wire        halt;
  wire [15:0] core_addr;
  wire [7:0]  core_wr_data;
  wire        core_rdwr;
  wire        core_sync;
  wire [15:0] dma_addr;
  wire [7:0]  dma_wr_data;
  wire        dma_rdwr;

  cpu_core u_cpu_core
  (
    .G_clock (G_clock),
    .G_reset (G_reset),
    .step    (core_step),
    .rd_data (G_rd_data),
    .addr    (core_addr),
    .wr_data (core_wr_data),
    .rdwr    (core_rdwr),
    .sync    (core_sync)
  );

  // the DMA unit watches the shared bus for the trigger write.
  oam_dma u_oam_dma
  (
    .G_clock     (G_clock),
    .G_reset     (G_reset),
    .step        (dma_step),
    .bus_addr    (G_addr),
    .bus_wr_data (G_wr_data),
    .bus_rdwr    (G_rdwr),
    .rd_data     (G_rd_data),
    .halt        (halt),
    .dma_addr    (dma_addr),
    .dma_wr_data (dma_wr_data),
    .dma_rdwr    (dma_rdwr)
  );

  bus_arbiter u_bus_arbiter
  (
    .G_clock      (G_clock),
    .G_reset      (G_reset),
    .halt         (halt),
    .core_addr    (core_addr),
    .core_wr_data (core_wr_data),
    .core_rdwr    (core_rdwr),
    .core_sync    (core_sync),
    .dma_addr     (dma_addr),
    .dma_wr_data  (dma_wr_data),
    .dma_rdwr     (dma_rdwr),
    .core_step    (core_step),
    .dma_step     (dma_step),
    .G_phy2       (G_phy2),
    .G_addr       (G_addr),
    .G_wr_data    (G_wr_data),
    .G_rdwr       (G_rdwr),
    .G_sync       (G_sync)
  );

endmodule

`default_nettype wire

/* verilog/q2a03_pkg.sv */
`default_nettype none

package q2a03_pkg;

  localparam int cycle_divide     = 12;
  localparam int phase_high_start = 6;

  localparam logic [15:0] reset_pc         = 16'hC000;
  localparam logic [15:0] dma_trigger_addr = 16'h4014;
  localparam logic [15:0] dma_target_addr  = 16'h2004;
  localparam int          dma_length       = 256;

  localparam logic [7:0] op_lda_imm = 8'hA9;
  localparam logic [7:0] op_lda_abs = 8'hAD;
  localparam logic [7:0] op_ldx_imm = 8'hA2;
  localparam logic [7:0] op_adc_imm = 8'h69;
  localparam logic [7:0] op_and_imm = 8'h29;
  localparam logic [7:0] op_eor_imm = 8'h49;
  localparam logic [7:0] op_sta_abs = 8'h8D;
  localparam logic [7:0] op_stx_abs = 8'h8E;
  localparam logic [7:0] op_inx     = 8'hE8;
  localparam logic [7:0] op_clc     = 8'h18;
  localparam logic [7:0] op_sec     = 8'h38;
  localparam logic [7:0] op_jmp_abs = 8'h4C;

  localparam int flag_c = 0;
  localparam int flag_z = 1;
  localparam int flag_n = 7;

  // the usual 6502 split of an opcode into aaa bbb cc.
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;   // addressing mode within the group.
    logic [1:0] cc;    // instruction group.
  } opcode_fields_t;

  typedef union packed {
    logic [7:0]     whole;
    opcode_fields_t field;
  } opcode_t;

endpackage

`default_nettype wire
